// ==== vlog.f ====
logic/rsa_pkg.sv
logic/mont_mult.sv
logic/mod_exp_ladder.sv
logic/rsa_dma_ctrl.sv
logic/rsa_top.sv
tb/rsa_sva.sv
tb/tb_rsa.sv

// ==== Bender.yml ====
package:
  name: rsa_modexp

sources:
  - logic/rsa_pkg.sv
  - logic/mont_mult.sv
  - logic/mod_exp_ladder.sv
  - logic/rsa_dma_ctrl.sv
  - logic/rsa_top.sv
  - target: simulation
    files:
      - tb/rsa_sva.sv
      - tb/tb_rsa.sv

// ==== tb/tb_rsa.sv ====
module tb_rsa;

  localparam int WIDTH        = 32;
  localparam int DONE_TIMEOUT = 10000;
  localparam int IDLE_TIMEOUT = 100;

  localparam rsa_pkg::status_t ST_DONE = 32'(1) << rsa_pkg::STATUS_DONE_BIT;
  localparam rsa_pkg::status_t ST_IDLE = 32'(1) << rsa_pkg::STATUS_IDLE_BIT;
  localparam rsa_pkg::status_t ST_ERR  = 32'(1) << rsa_pkg::STATUS_ERR_BIT;

  logic              clk = 1'b0;
  logic              resetn;
  rsa_pkg::command_e command;
  rsa_pkg::addr_t    addr_m, addr_e, addr_x, addr_r, addr_r2, addr_res;
  rsa_pkg::status_t  status;
  logic [WIDTH-1:0]  dma_rx_data;
  logic [WIDTH-1:0]  dma_tx_data;
  rsa_pkg::addr_t    dma_rx_address;
  rsa_pkg::addr_t    dma_tx_address;
  logic              dma_rx_start;
  logic              dma_tx_start;
  logic              dma_done;
  logic              dma_idle;
  logic              dma_error;

  logic [WIDTH-1:0]  mem [rsa_pkg::addr_t];
  rsa_pkg::addr_t    rx_addr_q [$];
  rsa_pkg::addr_t    exp_rd_addr [5];
  rsa_pkg::addr_t    exp_res_addr;
  logic [WIDTH-1:0]  exp_result;
  logic [31:0]       rng = 32'd26176;
  logic [31:0]       m_val, e_val, x_val, rnd_tmp;
  rsa_pkg::addr_t    base;
  logic              dma_is_rx;
  rsa_pkg::addr_t    dma_addr;
  logic [WIDTH-1:0]  dma_wdata;
  int unsigned       dma_lat;
  int unsigned       start_count = 0;
  int unsigned       write_count = 0;
  int unsigned       error_count = 0;
  int unsigned       test_count = 0;
  int unsigned       test_fail_count = 0;
  int unsigned       fails_at_start = 0;
  int unsigned       sva_fails;

  always #2 clk = ~clk;

  rsa_top #(
    .WIDTH (WIDTH)
  ) i_rsa_top (
    .clk            (clk),
    .resetn         (resetn),
    .command        (command),
    .addr_m         (addr_m),
    .addr_e         (addr_e),
    .addr_x         (addr_x),
    .addr_r         (addr_r),
    .addr_r2        (addr_r2),
    .addr_res       (addr_res),
    .status         (status),
    .dma_rx_data    (dma_rx_data),
    .dma_tx_data    (dma_tx_data),
    .dma_rx_address (dma_rx_address),
    .dma_tx_address (dma_tx_address),
    .dma_rx_start   (dma_rx_start),
    .dma_tx_start   (dma_tx_start),
    .dma_done       (dma_done),
    .dma_idle       (dma_idle),
    .dma_error      (dma_error)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Plain square-and-multiply over 64-bit products
  function automatic logic [WIDTH-1:0] ref_modexp(input logic [31:0] m, e, x);
    logic [63:0] acc;
    logic [63:0] sq;
    acc = 64'd1;
    sq  = {32'd0, x} % {32'd0, m};
    for (int i = 0; i < 32; i++) begin
      if (e[i]) acc = (acc * sq) % {32'd0, m};
      sq = (sq * sq) % {32'd0, m};
    end
    return acc[WIDTH-1:0];
  endfunction

  task automatic check_result(input logic [WIDTH-1:0] got, exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input rsa_pkg::status_t got, exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input rsa_pkg::addr_t got, exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (error_count == fails_at_start) begin
      $display("test %s: ok", name);
    end else begin
      test_fail_count++;
      $display("test %s: FAILED", name);
    end
    fails_at_start = error_count;
  endtask

  task automatic wait_status_bit(input int bit_idx, input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!status[bit_idx] && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!status[bit_idx]) begin
      $display("Timeout: %s did not appear within %0d cycles", what, limit);
      $display("sim failed");
      $finish;
    end
  endtask

  // DMA engine with random latency
  always @(posedge clk) begin
    if (resetn && (dma_rx_start || dma_tx_start)) begin
      start_count++;
      dma_is_rx = dma_rx_start;
      dma_addr  = dma_rx_start ? dma_rx_address : dma_tx_address;
      dma_wdata = dma_tx_data;
      if (dma_is_rx) rx_addr_q.push_back(dma_addr);
      dma_idle <= 1'b0;
      dma_lat = 1 + (next_rand() % 6);
      repeat (dma_lat) @(posedge clk);
      if (dma_is_rx) begin
        dma_rx_data <= mem.exists(dma_addr) ? mem[dma_addr] : '0;
      end else begin
        mem[dma_addr] = dma_wdata;
        write_count++;
      end
      dma_done <= 1'b1;
      @(posedge clk);
      dma_done <= 1'b0;
      dma_idle <= 1'b1;
    end
  end

  // Compare at the result write
  always @(posedge clk) begin
    if (resetn && dma_tx_start) begin
      check_result(dma_tx_data, exp_result, "written result");
      check_addr(dma_tx_address, exp_res_addr, "write address");
      if (rx_addr_q.size() != 5) begin
        error_count++;
        $display("[FAIL] %0t: saw %0d reads, expected 5", $time, rx_addr_q.size());
      end else begin
        for (int i = 0; i < 5; i++) check_addr(rx_addr_q[i], exp_rd_addr[i], "read address");
      end
    end
  end

  task automatic set_addresses(input rsa_pkg::addr_t a_m, a_e, a_x, a_r, a_r2, a_res);
    @(posedge clk);
    addr_m   <= a_m;
    addr_e   <= a_e;
    addr_x   <= a_x;
    addr_r   <= a_r;
    addr_r2  <= a_r2;
    addr_res <= a_res;
    exp_rd_addr[0] = a_m;
    exp_rd_addr[1] = a_e;
    exp_rd_addr[2] = a_x;
    exp_rd_addr[3] = a_r;
    exp_rd_addr[4] = a_r2;
    exp_res_addr   = a_res;
  endtask

  task automatic run_modexp(input logic [31:0] m, e, x, input int hold);
    logic [63:0] r_mod;
    logic [63:0] r2_mod;
    int unsigned writes_before;
    int unsigned starts_before;
    r_mod  = 64'h1_0000_0000 % {32'd0, m};
    r2_mod = (r_mod * r_mod) % {32'd0, m};
    exp_result = ref_modexp(m, e, x);
    mem[exp_rd_addr[0]] = m;
    mem[exp_rd_addr[1]] = e;
    mem[exp_rd_addr[2]] = x;
    mem[exp_rd_addr[3]] = r_mod[WIDTH-1:0];
    mem[exp_rd_addr[4]] = r2_mod[WIDTH-1:0];
    mem[exp_res_addr]   = ~exp_result;
    rx_addr_q.delete();
    writes_before = write_count;
    @(posedge clk);
    command <= rsa_pkg::CMD_COMPUTE;
    wait_status_bit(rsa_pkg::STATUS_DONE_BIT, DONE_TIMEOUT, "status done");
    check_status(status, ST_DONE, "status at done");
    check_result(mem[exp_res_addr], exp_result, "stored result");
    if (write_count != writes_before + 1) begin
      error_count++;
      $display("[FAIL] %0t: saw %0d writes, expected 1", $time, write_count - writes_before);
    end
    if (hold > 0) begin
      starts_before = start_count;
      repeat (hold) @(negedge clk);
      check_status(status, ST_DONE, "status while compute held");
      if (start_count != starts_before) begin
        error_count++;
        $display("[FAIL] %0t: DMA started while in done", $time);
      end
    end
    @(posedge clk);
    command <= rsa_pkg::CMD_IDLE;
    wait_status_bit(rsa_pkg::STATUS_IDLE_BIT, IDLE_TIMEOUT, "status idle");
    check_status(status, ST_IDLE, "status after idle command");
  endtask

  initial begin
    resetn      <= 1'b0;
    command     <= rsa_pkg::CMD_IDLE;
    addr_m      <= '0;
    addr_e      <= '0;
    addr_x      <= '0;
    addr_r      <= '0;
    addr_r2     <= '0;
    addr_res    <= '0;
    dma_rx_data <= '0;
    dma_done    <= 1'b0;
    dma_idle    <= 1'b1;
    dma_error   <= 1'b0;
    repeat (3) @(posedge clk);
    resetn <= 1'b1;

    @(negedge clk);
    check_status(status, ST_IDLE, "status after reset");
    repeat (20) @(negedge clk);
    if (start_count != 0) begin
      error_count++;
      $display("[FAIL] %0t: DMA started while command idle", $time);
    end
    end_test("reset_idle");

    set_addresses(32'h1000, 32'h1004, 32'h1008, 32'h100c, 32'h1010, 32'h1020);
    run_modexp(32'hC5A3_4F27, 32'h0001_0001, 32'h1234_5678, 0);
    end_test("fixed_case");

    for (int i = 0; i < 20; i++) begin
      m_val   = next_rand() | 32'h8000_0001;
      x_val   = next_rand() % m_val;
      rnd_tmp = next_rand();
      e_val   = next_rand() >> rnd_tmp[4:0];
      if (e_val == 0) e_val = 32'd1;
      base = next_rand() & 32'h000F_FF00;
      set_addresses(base, base + 4, base + 8, base + 12, base + 16, base + 20);
      run_modexp(m_val, e_val, x_val, 0);
      end_test($sformatf("random_%0d", i));
    end

    // Addresses out of numeric order
    set_addresses(32'h500, 32'h100, 32'h400, 32'h200, 32'h300, 32'h600);
    run_modexp(32'hF00D_0A01, 32'h0000_00F3, 32'h0BAD_CAFE, 0);
    end_test("read_order");

    run_modexp(32'h9E37_79B9, 32'h8000_0003, 32'h7F4A_7C15, 20);
    end_test("done_hold");

    @(posedge clk);
    dma_error <= 1'b1;
    @(negedge clk);
    check_status(status, ST_IDLE | ST_ERR, "status with dma_error");
    @(posedge clk);
    dma_error <= 1'b0;
    @(negedge clk);
    check_status(status, ST_IDLE, "status after dma_error release");
    end_test("dma_error");

    sva_fails = tb_rsa.i_rsa_top.i_ctrl.i_sva.assert_fails;
    $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
             test_count, test_fail_count, error_count, sva_fails);
    if (error_count == 0 && test_fail_count == 0 && sva_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== tb/rsa_sva.sv ====
module rsa_sva (
  input logic           clk,
  input logic           resetn,
  input logic           dma_rx_start,
  input logic           dma_tx_start,
  input rsa_pkg::addr_t dma_tx_address,
  input rsa_pkg::addr_t addr_res
);

  int unsigned assert_fails = 0;

  // Strobes last one cycle
  a_rx_pulse: assert property (@(posedge clk) disable iff (!resetn)
    dma_rx_start |=> !dma_rx_start)
    else begin
      $error("dma_rx_start held for more than one cycle");
      assert_fails++;
    end

  a_tx_pulse: assert property (@(posedge clk) disable iff (!resetn)
    dma_tx_start |=> !dma_tx_start)
    else begin
      $error("dma_tx_start held for more than one cycle");
      assert_fails++;
    end

  a_rx_tx_excl: assert property (@(posedge clk) disable iff (!resetn)
    !(dma_rx_start && dma_tx_start))
    else begin
      $error("dma_rx_start and dma_tx_start high together");
      assert_fails++;
    end

  a_no_start_in_reset: assert property (@(posedge clk)
    !resetn |=> (!dma_rx_start && !dma_tx_start))
    else begin
      $error("DMA start pulse during reset");
      assert_fails++;
    end

  a_tx_addr: assert property (@(posedge clk) disable iff (!resetn)
    dma_tx_start |-> (dma_tx_address == addr_res))
    else begin
      $error("dma_tx_address differs from addr_res at write start");
      assert_fails++;
    end

endmodule

bind rsa_dma_ctrl rsa_sva i_sva (
  .clk            (clk),
  .resetn         (resetn),
  .dma_rx_start   (dma_rx_start),
  .dma_tx_start   (dma_tx_start),
  .dma_tx_address (dma_tx_address),
  .addr_res       (addr_res)
);

// ==== logic/rsa_top.sv ====
module rsa_top #(
  parameter int WIDTH = 1024
) (
  input  logic              clk,
  input  logic              resetn,
  input  rsa_pkg::command_e command,
  input  rsa_pkg::addr_t    addr_m,
  input  rsa_pkg::addr_t    addr_e,
  input  rsa_pkg::addr_t    addr_x,
  input  rsa_pkg::addr_t    addr_r,
  input  rsa_pkg::addr_t    addr_r2,
  input  rsa_pkg::addr_t    addr_res,
  output rsa_pkg::status_t  status,
  input  logic [WIDTH-1:0]  dma_rx_data,
  output logic [WIDTH-1:0]  dma_tx_data,
  output rsa_pkg::addr_t    dma_rx_address,
  output rsa_pkg::addr_t    dma_tx_address,
  output logic              dma_rx_start,
  output logic              dma_tx_start,
  input  logic              dma_done,
  input  logic              dma_idle,
  input  logic              dma_error
);

  logic             ladder_start;
  logic             ladder_done;
  logic [WIDTH-1:0] ladder_result;
  logic [WIDTH-1:0] op_m;
  logic [WIDTH-1:0] op_e;
  logic [WIDTH-1:0] op_x;
  logic [WIDTH-1:0] op_r;
  logic [WIDTH-1:0] op_r2;

  rsa_dma_ctrl #(
    .WIDTH (WIDTH)
  ) i_ctrl (
    .clk            (clk),
    .resetn         (resetn),
    .command        (command),
    .addr_m         (addr_m),
    .addr_e         (addr_e),
    .addr_x         (addr_x),
    .addr_r         (addr_r),
    .addr_r2        (addr_r2),
    .addr_res       (addr_res),
    .dma_rx_data    (dma_rx_data),
    .dma_done       (dma_done),
    .dma_idle       (dma_idle),
    .dma_error      (dma_error),
    .ladder_result  (ladder_result),
    .ladder_done    (ladder_done),
    .status         (status),
    .dma_tx_data    (dma_tx_data),
    .dma_rx_address (dma_rx_address),
    .dma_tx_address (dma_tx_address),
    .dma_rx_start   (dma_rx_start),
    .dma_tx_start   (dma_tx_start),
    .ladder_start   (ladder_start),
    .op_m           (op_m),
    .op_e           (op_e),
    .op_x           (op_x),
    .op_r           (op_r),
    .op_r2          (op_r2)
  );

  mod_exp_ladder #(
    .WIDTH (WIDTH)
  ) i_ladder (
    .clk           (clk),
    .resetn        (resetn),
    .ladder_start  (ladder_start),
    .op_m          (op_m),
    .op_e          (op_e),
    .op_x          (op_x),
    .op_r          (op_r),
    .op_r2         (op_r2),
    .ladder_result (ladder_result),
    .ladder_done   (ladder_done)
  );

endmodule

// ==== logic/rsa_dma_ctrl.sv ====
module rsa_dma_ctrl #(
  parameter int WIDTH = 1024
) (
  input  logic              clk,
  input  logic              resetn,
  input  rsa_pkg::command_e command,
  input  rsa_pkg::addr_t    addr_m,
  input  rsa_pkg::addr_t    addr_e,
  input  rsa_pkg::addr_t    addr_x,
  input  rsa_pkg::addr_t    addr_r,
  input  rsa_pkg::addr_t    addr_r2,
  input  rsa_pkg::addr_t    addr_res,
  input  logic [WIDTH-1:0]  dma_rx_data,
  input  logic              dma_done,
  input  logic              dma_idle,
  input  logic              dma_error,
  input  logic [WIDTH-1:0]  ladder_result,
  input  logic              ladder_done,
  output rsa_pkg::status_t  status,
  output logic [WIDTH-1:0]  dma_tx_data,
  output rsa_pkg::addr_t    dma_rx_address,
  output rsa_pkg::addr_t    dma_tx_address,
  output logic              dma_rx_start,
  output logic              dma_tx_start,
  output logic              ladder_start,
  output logic [WIDTH-1:0]  op_m,
  output logic [WIDTH-1:0]  op_e,
  output logic [WIDTH-1:0]  op_x,
  output logic [WIDTH-1:0]  op_r,
  output logic [WIDTH-1:0]  op_r2
);

  rsa_pkg::ctrl_state_e state;
  rsa_pkg::operand_e    op_idx;
  logic [WIDTH-1:0]     res_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state        <= rsa_pkg::CTRL_IDLE;
      op_idx       <= rsa_pkg::OP_M;
      dma_rx_start <= 1'b0;
      dma_tx_start <= 1'b0;
    end else begin
      dma_rx_start <= 1'b0;
      dma_tx_start <= 1'b0;
      case (state)
        rsa_pkg::CTRL_IDLE: begin
          if (command == rsa_pkg::CMD_COMPUTE) begin
            op_idx <= rsa_pkg::OP_M;
            state  <= rsa_pkg::CTRL_RX_START;
          end
        end
        rsa_pkg::CTRL_RX_START: begin
          dma_rx_start <= 1'b1;
          state        <= rsa_pkg::CTRL_RX_BUSY;
        end
        // Engine acknowledges by leaving idle
        rsa_pkg::CTRL_RX_BUSY: if (!dma_idle) state <= rsa_pkg::CTRL_RX_WAIT;
        rsa_pkg::CTRL_RX_WAIT: begin
          if (dma_done) begin
            if (op_idx == rsa_pkg::OP_R2) begin
              state <= rsa_pkg::CTRL_COMPUTE;
            end else begin
              op_idx <= rsa_pkg::operand_e'(op_idx + 3'd1);
              state  <= rsa_pkg::CTRL_RX_START;
            end
          end
        end
        rsa_pkg::CTRL_COMPUTE:      state <= rsa_pkg::CTRL_COMPUTE_WAIT;
        rsa_pkg::CTRL_COMPUTE_WAIT: if (ladder_done) state <= rsa_pkg::CTRL_TX_START;
        rsa_pkg::CTRL_TX_START: begin
          dma_tx_start <= 1'b1;
          state        <= rsa_pkg::CTRL_TX_WAIT;
        end
        rsa_pkg::CTRL_TX_WAIT: if (dma_done) state <= rsa_pkg::CTRL_DONE;
        // Hold here so a lingering compute command does not restart
        rsa_pkg::CTRL_DONE: if (command == rsa_pkg::CMD_IDLE) state <= rsa_pkg::CTRL_IDLE;
        default: state <= rsa_pkg::CTRL_IDLE;
      endcase
    end
  end

  // Operand and result capture
  always_ff @(posedge clk) begin
    if (state == rsa_pkg::CTRL_RX_WAIT && dma_done) begin
      case (op_idx)
        rsa_pkg::OP_M:  op_m  <= dma_rx_data;
        rsa_pkg::OP_E:  op_e  <= dma_rx_data;
        rsa_pkg::OP_X:  op_x  <= dma_rx_data;
        rsa_pkg::OP_R:  op_r  <= dma_rx_data;
        rsa_pkg::OP_R2: op_r2 <= dma_rx_data;
        default: ;
      endcase
    end
    if (state == rsa_pkg::CTRL_COMPUTE_WAIT && ladder_done) begin
      res_q <= ladder_result;
    end
  end

  always_comb begin
    case (op_idx)
      rsa_pkg::OP_E:  dma_rx_address = addr_e;
      rsa_pkg::OP_X:  dma_rx_address = addr_x;
      rsa_pkg::OP_R:  dma_rx_address = addr_r;
      rsa_pkg::OP_R2: dma_rx_address = addr_r2;
      default:        dma_rx_address = addr_m;
    endcase
  end

  assign dma_tx_address = addr_res;
  assign dma_tx_data    = res_q;
  assign ladder_start   = (state == rsa_pkg::CTRL_COMPUTE);

  always_comb begin
    status = '0;
    status[rsa_pkg::STATUS_DONE_BIT] = (state == rsa_pkg::CTRL_DONE);
    status[rsa_pkg::STATUS_IDLE_BIT] = (state == rsa_pkg::CTRL_IDLE);
    status[rsa_pkg::STATUS_ERR_BIT]  = dma_error;
  end

endmodule

// ==== logic/mod_exp_ladder.sv ====
module mod_exp_ladder #(
  parameter int WIDTH = 1024
) (
  input  logic             clk,
  input  logic             resetn,
  input  logic             ladder_start,
  input  logic [WIDTH-1:0] op_m,
  input  logic [WIDTH-1:0] op_e,
  input  logic [WIDTH-1:0] op_x,
  input  logic [WIDTH-1:0] op_r,
  input  logic [WIDTH-1:0] op_r2,
  output logic [WIDTH-1:0] ladder_result,
  output logic             ladder_done
);

  localparam int CNT_W = $clog2(WIDTH);

  rsa_pkg::ladder_state_e state;
  logic [WIDTH-1:0] a_q;
  logic [WIDTH-1:0] xx_q;
  logic [WIDTH-1:0] e_sh;
  logic [CNT_W-1:0] pos_cnt;
  logic             e_top;
  logic             last_pos;
  logic             mm_start;
  logic             mm_done;
  logic [WIDTH-1:0] mm_a;
  logic [WIDTH-1:0] mm_b;
  logic [WIDTH-1:0] mm_result;

  assign e_top    = e_sh[WIDTH-1];
  assign last_pos = (pos_cnt == CNT_W'(WIDTH - 1));

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state   <= rsa_pkg::LAD_IDLE;
      pos_cnt <= '0;
    end else begin
      case (state)
        rsa_pkg::LAD_IDLE: begin
          if (ladder_start) begin
            pos_cnt <= '0;
            state   <= rsa_pkg::LAD_TO_MONT;
          end
        end
        rsa_pkg::LAD_TO_MONT:      state <= rsa_pkg::LAD_TO_MONT_WAIT;
        rsa_pkg::LAD_TO_MONT_WAIT: if (mm_done) state <= rsa_pkg::LAD_SCAN;
        // Skip leading zeros of the exponent
        rsa_pkg::LAD_SCAN: begin
          if (e_top) state <= rsa_pkg::LAD_MUL;
          else pos_cnt <= pos_cnt + 1'b1;
        end
        rsa_pkg::LAD_MUL:      state <= rsa_pkg::LAD_MUL_WAIT;
        rsa_pkg::LAD_MUL_WAIT: if (mm_done) state <= rsa_pkg::LAD_SQR;
        rsa_pkg::LAD_SQR:      state <= rsa_pkg::LAD_SQR_WAIT;
        rsa_pkg::LAD_SQR_WAIT: begin
          if (mm_done) begin
            if (last_pos) begin
              state <= rsa_pkg::LAD_FROM_MONT;
            end else begin
              pos_cnt <= pos_cnt + 1'b1;
              state   <= rsa_pkg::LAD_MUL;
            end
          end
        end
        rsa_pkg::LAD_FROM_MONT:      state <= rsa_pkg::LAD_FROM_MONT_WAIT;
        rsa_pkg::LAD_FROM_MONT_WAIT: if (mm_done) state <= rsa_pkg::LAD_FINISH;
        default: state <= rsa_pkg::LAD_IDLE;
      endcase
    end
  end

  // Working registers and exponent shifter
  always_ff @(posedge clk) begin
    case (state)
      rsa_pkg::LAD_IDLE: begin
        if (ladder_start) begin
          a_q  <= op_r;
          e_sh <= op_e;
        end
      end
      rsa_pkg::LAD_TO_MONT_WAIT: if (mm_done) xx_q <= mm_result;
      rsa_pkg::LAD_SCAN: if (!e_top) e_sh <= e_sh << 1;
      rsa_pkg::LAD_MUL_WAIT: begin
        if (mm_done) begin
          if (e_top) a_q <= mm_result;
          else xx_q <= mm_result;
        end
      end
      rsa_pkg::LAD_SQR_WAIT: begin
        if (mm_done) begin
          if (e_top) xx_q <= mm_result;
          else a_q <= mm_result;
          e_sh <= e_sh << 1;
        end
      end
      rsa_pkg::LAD_FROM_MONT_WAIT: if (mm_done) a_q <= mm_result;
      default: ;
    endcase
  end

  // Operands stay selected through the wait state
  always_comb begin
    case (state)
      rsa_pkg::LAD_TO_MONT, rsa_pkg::LAD_TO_MONT_WAIT: begin
        mm_a = op_x;
        mm_b = op_r2;
      end
      rsa_pkg::LAD_SQR, rsa_pkg::LAD_SQR_WAIT: begin
        mm_a = e_top ? xx_q : a_q;
        mm_b = e_top ? xx_q : a_q;
      end
      rsa_pkg::LAD_FROM_MONT, rsa_pkg::LAD_FROM_MONT_WAIT: begin
        mm_a = a_q;
        mm_b = WIDTH'(1);
      end
      default: begin
        mm_a = a_q;
        mm_b = xx_q;
      end
    endcase
  end

  assign mm_start = (state == rsa_pkg::LAD_TO_MONT) || (state == rsa_pkg::LAD_MUL) ||
                    (state == rsa_pkg::LAD_SQR) || (state == rsa_pkg::LAD_FROM_MONT);

  assign ladder_done   = (state == rsa_pkg::LAD_FINISH);
  assign ladder_result = a_q;

  mont_mult #(
    .WIDTH (WIDTH)
  ) i_mont_mult (
    .clk       (clk),
    .resetn    (resetn),
    .mm_start  (mm_start),
    .mm_a      (mm_a),
    .mm_b      (mm_b),
    .mm_m      (op_m),
    .mm_result (mm_result),
    .mm_done   (mm_done)
  );

endmodule

// ==== logic/mont_mult.sv ====
module mont_mult #(
  parameter int WIDTH = 1024
) (
  input  logic             clk,
  input  logic             resetn,
  input  logic             mm_start,
  input  logic [WIDTH-1:0] mm_a,
  input  logic [WIDTH-1:0] mm_b,
  input  logic [WIDTH-1:0] mm_m,
  output logic [WIDTH-1:0] mm_result,
  output logic             mm_done
);

  localparam int CNT_W = $clog2(WIDTH + 1);

  logic             running;
  logic [CNT_W-1:0] step_cnt;
  logic             sub_cycle;
  logic [WIDTH-1:0] a_sh;
  logic [WIDTH+1:0] acc;
  logic [WIDTH+1:0] m_ext;
  logic [WIDTH+1:0] sum_b;
  logic [WIDTH+1:0] sum_m;
  logic [WIDTH+1:0] acc_sub;

  assign m_ext     = {2'b00, mm_m};
  assign sub_cycle = (step_cnt == CNT_W'(WIDTH));

  // Add b for a set bit, then m to make the sum even
  assign sum_b   = acc + (a_sh[0] ? {2'b00, mm_b} : '0);
  assign sum_m   = sum_b + (sum_b[0] ? m_ext : '0);
  assign acc_sub = acc - m_ext;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      running  <= 1'b0;
      step_cnt <= '0;
      mm_done  <= 1'b0;
    end else begin
      mm_done <= 1'b0;
      if (mm_start) begin
        running  <= 1'b1;
        step_cnt <= '0;
      end else if (running) begin
        if (sub_cycle) begin
          running <= 1'b0;
          mm_done <= 1'b1;
        end else begin
          step_cnt <= step_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mm_start) begin
      acc  <= '0;
      a_sh <= mm_a;
    end else if (running && !sub_cycle) begin
      acc  <= sum_m >> 1;
      a_sh <= a_sh >> 1;
    end
    // acc is below 2m here, one subtraction is enough
    if (running && sub_cycle) begin
      mm_result <= (acc >= m_ext) ? acc_sub[WIDTH-1:0] : acc[WIDTH-1:0];
    end
  end

endmodule

// ==== logic/rsa_pkg.sv ====
package rsa_pkg;

  // Host and DMA bus word
  localparam int unsigned ADDR_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [31:0] status_t;

  localparam int unsigned STATUS_DONE_BIT = 0;
  localparam int unsigned STATUS_IDLE_BIT = 1;
  localparam int unsigned STATUS_ERR_BIT  = 2;

  typedef enum logic [31:0] {
    CMD_IDLE    = 32'd0,
    CMD_COMPUTE = 32'd1
  } command_e;

  typedef enum logic [3:0] {
    CTRL_IDLE,
    CTRL_RX_START,
    CTRL_RX_BUSY,
    CTRL_RX_WAIT,
    CTRL_COMPUTE,
    CTRL_COMPUTE_WAIT,
    CTRL_TX_START,
    CTRL_TX_WAIT,
    CTRL_DONE
  } ctrl_state_e;

  // Load order of the five reads
  typedef enum logic [2:0] {
    OP_M,
    OP_E,
    OP_X,
    OP_R,
    OP_R2
  } operand_e;

  typedef enum logic [3:0] {
    LAD_IDLE,
    LAD_TO_MONT,
    LAD_TO_MONT_WAIT,
    LAD_SCAN,
    LAD_MUL,
    LAD_MUL_WAIT,
    LAD_SQR,
    LAD_SQR_WAIT,
    LAD_FROM_MONT,
    LAD_FROM_MONT_WAIT,
    LAD_FINISH
  } ladder_state_e;

endpackage
